// File: list.f
verilog/cache_geom_pkg.sv
verilog/cache_cmd_pkg.sv
verilog/mshr_entry_decode.sv
verilog/mshr_entry_progress.sv
verilog/mshr_entry_issue.sv
verilog/mshr_entry_top.sv
dv/mshr_entry_chk.sv
dv/mshr_entry_tb.sv

// File: dv/mshr_entry_tb.sv
`timescale 1ns/1ps

module mshr_entry_tb;

    localparam int ENTRY_NUM = 8;
    localparam int TIMEOUT   = 200;
    localparam int NDIR      = cache_cmd_pkg::NUM_DIRS;
    localparam int TAG_W     = cache_geom_pkg::TAG_WIDTH;
    localparam int IDX_W     = cache_geom_pkg::INDEX_WIDTH;
    localparam int HASH_W    = cache_geom_pkg::HASH_WIDTH;
    localparam int DEST_W    = cache_geom_pkg::DEST_RAM_WIDTH;
    localparam int DB_W      = cache_geom_pkg::DB_ID_WIDTH;

    logic clk, rst_n, alloc_vld, alloc_rdy, upd_en, upd_hit, upd_hzd_pass;
    cache_cmd_pkg::cmd_opcode_t upd_opcode, ds_req_opcode;
    cache_cmd_pkg::direction_t upd_direction, req_direction;
    logic [ENTRY_NUM-1:0] upd_hzd_bitmap, release_vec;
    logic [cache_geom_pkg::MASTER_ID_WIDTH-1:0] upd_master_id, req_master_id;
    logic [TAG_W-1:0] upd_tag, req_tag, hzd_tag;
    logic [IDX_W-1:0] upd_index, req_index, hzd_index;
    logic [cache_geom_pkg::OFFSET_WIDTH-1:0] upd_offset, req_offset;
    logic [cache_geom_pkg::WAY_WIDTH-1:0] upd_way, req_way;
    logic [cache_geom_pkg::ROB_ID_WIDTH-1:0] upd_rob_id, req_rob_id;
    logic ds_req_vld, ds_req_rdy, ds_done, lf_req_vld, lf_req_rdy, linefill_done;
    logic [DB_W-1:0] ds_done_db_id, lf_db_id;
    logic [NDIR-1:0] dram_rd_vld, dram_rd_rdy, dram_wr_vld, dram_wr_rdy;
    logic [NDIR-1:0] rdb_nfull, rd_done, wr_done;
    logic [HASH_W-1:0] req_hash_id;
    logic [DEST_W-1:0] req_dest_ram_id;
    logic hzd_valid, release_en;

    integer seed;
    int n_checks, n_errors;
    logic [15:0] exp_order, seen_order;     // one nibble per phase with 1 ds 2 lf 3 rd 4 wr
    logic [NDIR-1:0] exp_dir_oh;
    logic [DEST_W-1:0] exp_dest;
    logic [HASH_W-1:0] exp_hash;
    logic [DB_W-1:0] exp_db;
    cache_cmd_pkg::cmd_opcode_t exp_opcode;
    logic [47:0] exp_fields, req_fields;
    logic [9:0] vlds, prev_vlds;
    logic [51:0] prev_fields;
    logic hold_pending, ds_done_given, lf_done_given;
    logic [31:0] rdy_rnd;

    assign req_fields = {req_tag, req_index, req_offset, req_way, req_rob_id, req_master_id,
                         req_direction};
    assign vlds = {ds_req_vld, lf_req_vld, dram_rd_vld, dram_wr_vld};

    mshr_entry_top #(.ENTRY_NUM(ENTRY_NUM)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // random ready stalls on every channel
    always @(posedge clk) begin
        rdy_rnd = $random(seed);
        ds_req_rdy  <= rdy_rnd[0];
        lf_req_rdy  <= rdy_rnd[1];
        dram_rd_rdy <= rdy_rnd[5:2];
        dram_wr_rdy <= rdy_rnd[9:6];
    end

    task automatic check(input string name, input logic [63:0] exp_val,
                         input logic [63:0] act_val);
        n_checks++;
        if (exp_val !== act_val) begin
            n_errors++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, exp_val, act_val);
        end
    endtask

    // expected phase order, direction bit and routing ids of one request
    function automatic void ref_txn(input cache_cmd_pkg::cmd_opcode_t op, input logic hit,
                                    input cache_cmd_pkg::direction_t dir,
                                    input logic [TAG_W-1:0] tag, input logic [IDX_W-1:0] index,
                                    output logic [15:0] order, output logic [NDIR-1:0] dir_oh,
                                    output logic [DEST_W-1:0] dest,
                                    output logic [HASH_W-1:0] hash);
        order = hit ? 16'h0000 : 16'h0012;
        order = {order[11:0], (op == cache_cmd_pkg::CMD_READ) ? 4'h3 : 4'h4};
        for (int i = 0; i < NDIR; i++)
            dir_oh[i] = (i == int'(dir));
        hash = tag[TAG_W-1 -: 2];
        dest = {tag[TAG_W-1 -: 2], index[IDX_W-1 -: 3]};
    endfunction

    function automatic logic cond_met(input int sel);
        case (sel)
            0: cond_met = alloc_vld;
            1: cond_met = ds_req_vld && ds_req_rdy;
            2: cond_met = lf_req_vld && lf_req_rdy;
            3: cond_met = |(dram_rd_vld & dram_rd_rdy);
            4: cond_met = |(dram_wr_vld & dram_wr_rdy);
            default: cond_met = release_en;
        endcase
    endfunction

    // returns at the edge where the condition holds
    task automatic wait_until(input int sel, input string what);
        int n;
        n = 0;
        @(posedge clk);
        while (!cond_met(sel) && n < TIMEOUT) begin
            n++;
            @(posedge clk);
        end
        if (!cond_met(sel)) begin
            $display("timeout while waiting for %s", what);
            $display("Simulation FAILED");
            $finish;
        end
    endtask

    // ======================================================================
    // compare process
    // ======================================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            hold_pending = 1'b0;
        end else begin
            if (hold_pending) begin
                check("valid held under stall", prev_vlds, vlds);
                check("fields held under stall", prev_fields, {req_fields, lf_db_id});
            end
            check("dram valid one-hot", 1, $onehot0({dram_rd_vld, dram_wr_vld}));
            if (ds_req_vld && ds_req_rdy) begin
                seen_order = {seen_order[11:0], 4'h1};
                check("ds opcode", exp_opcode, ds_req_opcode);
                check("ds fields", exp_fields, req_fields);
                check("ds dest_ram_id", exp_dest, req_dest_ram_id);
            end
            if (lf_req_vld && lf_req_rdy) begin
                seen_order = {seen_order[11:0], 4'h2};
                check("lf after ds_done", 1, ds_done_given);
                check("lf_db_id", exp_db, lf_db_id);
            end
            if (|(dram_rd_vld & dram_rd_rdy) || |(dram_wr_vld & dram_wr_rdy)) begin
                seen_order = {seen_order[11:0], (|dram_rd_vld) ? 4'h3 : 4'h4};
                check("dram after linefill", 1, lf_done_given);
                check("dram direction", exp_dir_oh, dram_rd_vld | dram_wr_vld);
                check("dram fields", exp_fields, req_fields);
                check("dram dest_ram_id", exp_dest, req_dest_ram_id);
                check("dram hash_id", exp_hash, req_hash_id);
            end
            hold_pending = (ds_req_vld && !ds_req_rdy) || (lf_req_vld && !lf_req_rdy) ||
                           ((|dram_rd_vld) && !(|(dram_rd_vld & dram_rd_rdy))) ||
                           ((|dram_wr_vld) && !(|(dram_wr_vld & dram_wr_rdy)));
            prev_vlds   = vlds;
            prev_fields = {req_fields, lf_db_id};
        end
    end

    task automatic run_txn(input cache_cmd_pkg::cmd_opcode_t op, input logic hit,
                           input logic [ENTRY_NUM-1:0] bitmap);
        logic [31:0] r;
        logic [31:0] s;
        cache_cmd_pkg::direction_t dir;
        r = $random(seed);
        s = $random(seed);
        dir = cache_cmd_pkg::direction_t'(s[23:22]);
        ref_txn(op, hit, dir, r[19:0], r[27:20], exp_order, exp_dir_oh, exp_dest, exp_hash);
        exp_fields    = {r[19:0], r[27:20], s[5:0], s[8:6], s[13:9], s[17:14], dir};
        exp_opcode    = op;
        seen_order    = '0;
        ds_done_given = 1'b0;
        lf_done_given = hit;
        wait_until(0, "alloc_vld");
        alloc_rdy <= 1'b1;
        @(posedge clk);
        alloc_rdy      <= 1'b0;
        upd_en         <= 1'b1;
        upd_opcode     <= op;
        upd_hit        <= hit;
        upd_hzd_pass   <= (bitmap == '0);
        upd_hzd_bitmap <= bitmap;
        upd_direction  <= dir;
        upd_tag        <= r[19:0];
        upd_index      <= r[27:20];
        upd_offset     <= s[5:0];
        upd_way        <= s[8:6];
        upd_rob_id     <= s[13:9];
        upd_master_id  <= s[17:14];
        rdb_nfull      <= {NDIR{!(hit && op == cache_cmd_pkg::CMD_READ)}};
        @(posedge clk);
        upd_en <= 1'b0;
        check("alloc_vld after transfer", 0, alloc_vld);
        // older entries release one by one
        for (int k = 0; k < ENTRY_NUM; k++) begin
            if (bitmap[k]) begin
                @(posedge clk);
                release_vec <= ENTRY_NUM'(1) << k;
                @(posedge clk);
                release_vec <= '0;
                check("no valid in hazard wait", 0, vlds);
                check("hzd_valid in hazard wait", 1, hzd_valid);
                check("hzd_tag", r[19:0], hzd_tag);
                check("hzd_index", r[27:20], hzd_index);
            end
        end
        if (!hit) begin
            wait_until(1, "downstream request transfer");
            repeat (2) @(posedge clk);
            ds_done       <= 1'b1;
            ds_done_db_id <= s[21:18];
            exp_db        = s[21:18];
            ds_done_given = 1'b1;
            @(posedge clk);
            ds_done <= 1'b0;
            wait_until(2, "linefill request transfer");
            repeat (2) @(posedge clk);
            linefill_done <= 1'b1;
            lf_done_given = 1'b1;
            @(posedge clk);
            linefill_done <= 1'b0;
        end else if (op == cache_cmd_pkg::CMD_READ) begin
            repeat (3) begin
                @(posedge clk);
                check("read gated by rdb_nfull", 0, dram_rd_vld);
            end
            rdb_nfull <= exp_dir_oh;
        end
        wait_until((op == cache_cmd_pkg::CMD_READ) ? 3 : 4, "data ram transfer");
        repeat (2) @(posedge clk);
        if (op == cache_cmd_pkg::CMD_READ)
            rd_done <= exp_dir_oh;
        else
            wr_done <= exp_dir_oh;
        @(posedge clk);
        rd_done <= '0;
        wr_done <= '0;
        wait_until(5, "release_en");
        @(posedge clk);
        check("release_en single pulse", 0, release_en);
        check("alloc_vld after release", 1, alloc_vld);
        check("phase order", exp_order, seen_order);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        logic [31:0] r;
        seed = 32'h4097;
        n_checks = 0;
        n_errors = 0;
        rst_n = 1'b0;
        alloc_rdy = 1'b0;
        upd_en = 1'b0;
        upd_opcode = cache_cmd_pkg::CMD_READ;
        upd_hit = 1'b0;
        upd_hzd_pass = 1'b0;
        upd_hzd_bitmap = '0;
        upd_direction = cache_cmd_pkg::DIR_WEST;
        upd_master_id = '0;
        upd_tag = '0;
        upd_index = '0;
        upd_offset = '0;
        upd_way = '0;
        upd_rob_id = '0;
        ds_req_rdy = 1'b0;
        lf_req_rdy = 1'b0;
        dram_rd_rdy = '0;
        dram_wr_rdy = '0;
        ds_done = 1'b0;
        ds_done_db_id = '0;
        linefill_done = 1'b0;
        rdb_nfull = '0;
        rd_done = '0;
        wr_done = '0;
        release_vec = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check("alloc_vld after reset", 1, alloc_vld);
        check("valids after reset", 0, vlds);
        check("hzd_valid after reset", 0, hzd_valid);
        check("release_en after reset", 0, release_en);
        run_txn(cache_cmd_pkg::CMD_READ, 1'b1, '0);
        run_txn(cache_cmd_pkg::CMD_WRITE, 1'b1, '0);
        run_txn(cache_cmd_pkg::CMD_READ, 1'b0, '0);
        run_txn(cache_cmd_pkg::CMD_WRITE, 1'b0, 8'h25);   // miss behind three older entries
        run_txn(cache_cmd_pkg::CMD_READ, 1'b1, 8'h81);
        repeat (6) begin
            r = $random(seed);
            run_txn(r[0] ? cache_cmd_pkg::CMD_WRITE : cache_cmd_pkg::CMD_READ, r[1],
                    r[2] ? r[15:8] : '0);
        end
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: dv/mshr_entry_chk.sv
`timescale 1ns/1ps

module mshr_entry_chk (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                hazard_free,
    input  logic                                ds_req_vld,
    input  logic                                ds_req_rdy,
    input  logic                                lf_req_vld,
    input  logic                                lf_req_rdy,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]  dram_rd_vld,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]  dram_rd_rdy,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]  dram_wr_vld,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]  dram_wr_rdy
);

    one_dram_vld: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({dram_rd_vld, dram_wr_vld}))
        else $error("more than one data ram valid bit set");

    ds_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ds_req_vld && !ds_req_rdy |=> ds_req_vld)
        else $error("downstream valid dropped before its transfer");

    lf_hold: assert property (@(posedge clk) disable iff (!rst_n)
        lf_req_vld && !lf_req_rdy |=> lf_req_vld)
        else $error("linefill valid dropped before its transfer");

    // stalled dram valid keeps its direction bit
    rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (|dram_rd_vld) && !(|(dram_rd_vld & dram_rd_rdy)) |=> dram_rd_vld == $past(dram_rd_vld))
        else $error("data ram read valid changed before its transfer");

    wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (|dram_wr_vld) && !(|(dram_wr_vld & dram_wr_rdy)) |=> dram_wr_vld == $past(dram_wr_vld))
        else $error("data ram write valid changed before its transfer");

    no_vld_in_hazard: assert property (@(posedge clk) disable iff (!rst_n)
        !hazard_free |-> !ds_req_vld && !lf_req_vld && !(|dram_rd_vld) && !(|dram_wr_vld))
        else $error("request valid high while hazard wait is pending");

endmodule

// issue is combinational, clock and reset come from the enclosing top
bind mshr_entry_issue mshr_entry_chk chk_i (
    .clk(mshr_entry_top.clk),
    .rst_n(mshr_entry_top.rst_n),
    .hazard_free(hazard_free),
    .ds_req_vld(ds_req_vld),
    .ds_req_rdy(ds_req_rdy),
    .lf_req_vld(lf_req_vld),
    .lf_req_rdy(lf_req_rdy),
    .dram_rd_vld(dram_rd_vld),
    .dram_rd_rdy(dram_rd_rdy),
    .dram_wr_vld(dram_wr_vld),
    .dram_wr_rdy(dram_wr_rdy)
);

// File: verilog/mshr_entry_top.sv
`timescale 1ns/1ps

module mshr_entry_top #(
    parameter int ENTRY_NUM = 8
) (
    input  logic                                            clk,
    input  logic                                            rst_n,
    // alloc and update
    output logic                                            alloc_vld,
    input  logic                                            alloc_rdy,
    input  logic                                            upd_en,
    input  cache_cmd_pkg::cmd_opcode_t                      upd_opcode,
    input  logic                                            upd_hit,
    input  logic                                            upd_hzd_pass,
    input  logic [ENTRY_NUM-1:0]                            upd_hzd_bitmap,
    input  cache_cmd_pkg::direction_t                       upd_direction,
    input  logic [cache_geom_pkg::MASTER_ID_WIDTH-1:0]      upd_master_id,
    input  logic [cache_geom_pkg::TAG_WIDTH-1:0]            upd_tag,
    input  logic [cache_geom_pkg::INDEX_WIDTH-1:0]          upd_index,
    input  logic [cache_geom_pkg::OFFSET_WIDTH-1:0]         upd_offset,
    input  logic [cache_geom_pkg::WAY_WIDTH-1:0]            upd_way,
    input  logic [cache_geom_pkg::ROB_ID_WIDTH-1:0]         upd_rob_id,
    // downstream
    output logic                                            ds_req_vld,
    input  logic                                            ds_req_rdy,
    output cache_cmd_pkg::cmd_opcode_t                      ds_req_opcode,
    input  logic                                            ds_done,
    input  logic [cache_geom_pkg::DB_ID_WIDTH-1:0]          ds_done_db_id,
    // linefill
    output logic                                            lf_req_vld,
    input  logic                                            lf_req_rdy,
    output logic [cache_geom_pkg::DB_ID_WIDTH-1:0]          lf_db_id,
    input  logic                                            linefill_done,
    // data ram
    output logic [cache_cmd_pkg::NUM_DIRS-1:0]              dram_rd_vld,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]              dram_rd_rdy,
    output logic [cache_cmd_pkg::NUM_DIRS-1:0]              dram_wr_vld,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]              dram_wr_rdy,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]              rdb_nfull,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]              rd_done,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]              wr_done,
    // shared request fields
    output logic [cache_geom_pkg::TAG_WIDTH-1:0]            req_tag,
    output logic [cache_geom_pkg::INDEX_WIDTH-1:0]          req_index,
    output logic [cache_geom_pkg::OFFSET_WIDTH-1:0]         req_offset,
    output logic [cache_geom_pkg::WAY_WIDTH-1:0]            req_way,
    output logic [cache_geom_pkg::ROB_ID_WIDTH-1:0]         req_rob_id,
    output logic [cache_geom_pkg::MASTER_ID_WIDTH-1:0]      req_master_id,
    output cache_cmd_pkg::direction_t                       req_direction,
    output logic [cache_geom_pkg::HASH_WIDTH-1:0]           req_hash_id,
    output logic [cache_geom_pkg::DEST_RAM_WIDTH-1:0]       req_dest_ram_id,
    // hazard view
    input  logic [ENTRY_NUM-1:0]                            release_vec,
    output logic                                            hzd_valid,
    output logic [cache_geom_pkg::TAG_WIDTH-1:0]            hzd_tag,
    output logic [cache_geom_pkg::INDEX_WIDTH-1:0]          hzd_index,
    output logic                                            release_en
);

    logic new_is_read, new_is_write, new_miss;
    logic active, hazard_free;
    logic ds_pending, lf_ready, line_present, rd_pending, wr_pending;
    logic ds_req_fire, lf_req_fire, rd_fire, wr_fire;

    mshr_entry_decode u_decode (
        .clk(clk), .rst_n(rst_n), .upd_en(upd_en),
        .upd_opcode(upd_opcode), .upd_hit(upd_hit), .upd_direction(upd_direction),
        .upd_master_id(upd_master_id), .upd_tag(upd_tag), .upd_index(upd_index),
        .upd_offset(upd_offset), .upd_way(upd_way), .upd_rob_id(upd_rob_id),
        .ds_done(ds_done), .ds_done_db_id(ds_done_db_id),
        .new_is_read(new_is_read), .new_is_write(new_is_write), .new_miss(new_miss),
        .ent_opcode(ds_req_opcode), .ent_direction(req_direction),
        .ent_master_id(req_master_id), .ent_tag(req_tag), .ent_index(req_index),
        .ent_offset(req_offset), .ent_way(req_way), .ent_rob_id(req_rob_id),
        .ent_db_id(lf_db_id)
    );

    mshr_entry_progress #(.ENTRY_NUM(ENTRY_NUM)) u_progress (
        .clk(clk), .rst_n(rst_n), .alloc_rdy(alloc_rdy),
        .upd_en(upd_en), .upd_hzd_pass(upd_hzd_pass), .upd_hzd_bitmap(upd_hzd_bitmap),
        .release_vec(release_vec),
        .new_is_read(new_is_read), .new_is_write(new_is_write), .new_miss(new_miss),
        .ds_req_fire(ds_req_fire), .lf_req_fire(lf_req_fire),
        .rd_fire(rd_fire), .wr_fire(wr_fire),
        .ds_done(ds_done), .linefill_done(linefill_done),
        .rd_done(rd_done), .wr_done(wr_done),
        .alloc_vld(alloc_vld), .active(active), .hazard_free(hazard_free),
        .ds_pending(ds_pending), .lf_ready(lf_ready), .line_present(line_present),
        .rd_pending(rd_pending), .wr_pending(wr_pending), .release_en(release_en)
    );

    mshr_entry_issue u_issue (
        .active(active), .hazard_free(hazard_free), .release_en(release_en),
        .ds_pending(ds_pending), .lf_ready(lf_ready), .line_present(line_present),
        .rd_pending(rd_pending), .wr_pending(wr_pending),
        .ent_direction(req_direction), .ent_tag(req_tag), .ent_index(req_index),
        .rdb_nfull(rdb_nfull),
        .ds_req_rdy(ds_req_rdy), .lf_req_rdy(lf_req_rdy),
        .dram_rd_rdy(dram_rd_rdy), .dram_wr_rdy(dram_wr_rdy),
        .ds_req_vld(ds_req_vld), .lf_req_vld(lf_req_vld),
        .dram_rd_vld(dram_rd_vld), .dram_wr_vld(dram_wr_vld),
        .ds_req_fire(ds_req_fire), .lf_req_fire(lf_req_fire),
        .rd_fire(rd_fire), .wr_fire(wr_fire),
        .req_hash_id(req_hash_id), .req_dest_ram_id(req_dest_ram_id),
        .hzd_valid(hzd_valid)
    );

    // other entries compare against our address
    assign hzd_tag   = req_tag;
    assign hzd_index = req_index;

endmodule

// File: verilog/mshr_entry_issue.sv
`timescale 1ns/1ps

module mshr_entry_issue (
    input  logic                                        active,
    input  logic                                        hazard_free,
    input  logic                                        release_en,
    input  logic                                        ds_pending,
    input  logic                                        lf_ready,
    input  logic                                        line_present,
    input  logic                                        rd_pending,
    input  logic                                        wr_pending,
    input  cache_cmd_pkg::direction_t                   ent_direction,
    input  logic [cache_geom_pkg::TAG_WIDTH-1:0]        ent_tag,
    input  logic [cache_geom_pkg::INDEX_WIDTH-1:0]      ent_index,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]          rdb_nfull,
    input  logic                                        ds_req_rdy,
    input  logic                                        lf_req_rdy,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]          dram_rd_rdy,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]          dram_wr_rdy,
    output logic                                        ds_req_vld,
    output logic                                        lf_req_vld,
    output logic [cache_cmd_pkg::NUM_DIRS-1:0]          dram_rd_vld,
    output logic [cache_cmd_pkg::NUM_DIRS-1:0]          dram_wr_vld,
    output logic                                        ds_req_fire,
    output logic                                        lf_req_fire,
    output logic                                        rd_fire,
    output logic                                        wr_fire,
    output logic [cache_geom_pkg::HASH_WIDTH-1:0]       req_hash_id,
    output logic [cache_geom_pkg::DEST_RAM_WIDTH-1:0]   req_dest_ram_id,
    output logic                                        hzd_valid
);

    localparam int NDIR    = cache_cmd_pkg::NUM_DIRS;
    localparam int TAG_W   = cache_geom_pkg::TAG_WIDTH;
    localparam int IDX_W   = cache_geom_pkg::INDEX_WIDTH;
    localparam int HASH_W  = cache_geom_pkg::HASH_WIDTH;
    localparam int IDX_TOP = cache_geom_pkg::DEST_RAM_WIDTH - HASH_W;

    logic [NDIR-1:0] dir_oh;
    logic            rd_go;
    logic            wr_go;

    assign dir_oh = {{(NDIR-1){1'b0}}, 1'b1} << ent_direction;

    // ==================================================================
    // request valids
    // ==================================================================
    assign ds_req_vld = hazard_free && ds_pending;
    assign lf_req_vld = hazard_free && lf_ready;

    // dram access once the line is in
    assign rd_go = hazard_free && line_present && rd_pending;
    assign wr_go = hazard_free && line_present && wr_pending;

    assign dram_rd_vld = {NDIR{rd_go}} & dir_oh & rdb_nfull;  // needs read buffer room
    assign dram_wr_vld = {NDIR{wr_go}} & dir_oh;

    assign ds_req_fire = ds_req_vld && ds_req_rdy;
    assign lf_req_fire = lf_req_vld && lf_req_rdy;
    assign rd_fire     = |(dram_rd_vld & dram_rd_rdy);
    assign wr_fire     = |(dram_wr_vld & dram_wr_rdy);

    // ==================================================================
    // routing ids and hazard view
    // ==================================================================
    assign req_hash_id     = ent_tag[TAG_W-1 -: HASH_W];
    assign req_dest_ram_id = {ent_tag[TAG_W-1 -: HASH_W], ent_index[IDX_W-1 -: IDX_TOP]};

    assign hzd_valid = active && !release_en;

endmodule

// File: verilog/mshr_entry_progress.sv
`timescale 1ns/1ps

module mshr_entry_progress #(
    parameter int ENTRY_NUM = 8
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                alloc_rdy,
    input  logic                                upd_en,
    input  logic                                upd_hzd_pass,
    input  logic [ENTRY_NUM-1:0]                upd_hzd_bitmap,
    input  logic [ENTRY_NUM-1:0]                release_vec,
    input  logic                                new_is_read,
    input  logic                                new_is_write,
    input  logic                                new_miss,
    input  logic                                ds_req_fire,
    input  logic                                lf_req_fire,
    input  logic                                rd_fire,
    input  logic                                wr_fire,
    input  logic                                ds_done,
    input  logic                                linefill_done,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]  rd_done,
    input  logic [cache_cmd_pkg::NUM_DIRS-1:0]  wr_done,
    output logic                                alloc_vld,
    output logic                                active,
    output logic                                hazard_free,
    output logic                                ds_pending,
    output logic                                lf_ready,
    output logic                                line_present,
    output logic                                rd_pending,
    output logic                                wr_pending,
    output logic                                release_en
);

    localparam int PH_DS = 0;
    localparam int PH_LF = 1;
    localparam int PH_RD = 2;
    localparam int PH_WR = 3;

    logic                 idle;
    logic [ENTRY_NUM-1:0] hzd_bitmap;
    logic [3:0]           need;
    logic [3:0]           sent;       // request handed over
    logic [3:0]           done;       // completion seen
    logic [3:0]           sent_set;
    logic [3:0]           done_set;

    // ==================================================================
    // alloc / active
    // ==================================================================
    assign alloc_vld = idle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle   <= 1'b1;
            active <= 1'b0;
        end else begin
            if (alloc_vld && alloc_rdy)
                idle <= 1'b0;
            else if (release_en)
                idle <= 1'b1;
            if (upd_en)
                active <= 1'b1;
            else if (release_en)
                active <= 1'b0;
        end
    end

    // ==================================================================
    // hazard wait on older entries
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hzd_bitmap  <= '0;
            hazard_free <= 1'b0;
        end else begin
            if (upd_en)
                hzd_bitmap <= upd_hzd_pass ? '0 : upd_hzd_bitmap;   // pass means no wait
            else
                hzd_bitmap <= hzd_bitmap & ~release_vec;
            hazard_free <= (upd_en && upd_hzd_pass) ||
                           (active && !release_en && !(|hzd_bitmap));
        end
    end

    // ==================================================================
    // phase flags where 1 means nothing left to do
    // ==================================================================
    assign need     = {new_is_write, new_is_read, new_miss, new_miss};
    assign sent_set = {wr_fire, rd_fire, lf_req_fire, ds_req_fire};
    assign done_set = {|wr_done, |rd_done, linefill_done, ds_done};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sent <= '1;
            done <= '1;
        end else if (upd_en) begin
            sent <= ~need;
            done <= ~need;
        end else begin
            sent <= sent | sent_set;
            done <= done | done_set;
        end
    end

    assign ds_pending   = ~sent[PH_DS];
    assign lf_ready     = done[PH_DS] & ~sent[PH_LF];   // fill back but linefill not sent
    assign line_present = done[PH_LF];
    assign rd_pending   = ~sent[PH_RD];
    assign wr_pending   = ~sent[PH_WR];

    assign release_en = active && done[PH_RD] && done[PH_WR];

endmodule

// File: verilog/mshr_entry_decode.sv
`timescale 1ns/1ps

module mshr_entry_decode (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            upd_en,
    input  cache_cmd_pkg::cmd_opcode_t                      upd_opcode,
    input  logic                                            upd_hit,
    input  cache_cmd_pkg::direction_t                       upd_direction,
    input  logic [cache_geom_pkg::MASTER_ID_WIDTH-1:0]      upd_master_id,
    input  logic [cache_geom_pkg::TAG_WIDTH-1:0]            upd_tag,
    input  logic [cache_geom_pkg::INDEX_WIDTH-1:0]          upd_index,
    input  logic [cache_geom_pkg::OFFSET_WIDTH-1:0]         upd_offset,
    input  logic [cache_geom_pkg::WAY_WIDTH-1:0]            upd_way,
    input  logic [cache_geom_pkg::ROB_ID_WIDTH-1:0]         upd_rob_id,
    input  logic                                            ds_done,
    input  logic [cache_geom_pkg::DB_ID_WIDTH-1:0]          ds_done_db_id,
    output logic                                            new_is_read,
    output logic                                            new_is_write,
    output logic                                            new_miss,
    output cache_cmd_pkg::cmd_opcode_t                      ent_opcode,
    output cache_cmd_pkg::direction_t                       ent_direction,
    output logic [cache_geom_pkg::MASTER_ID_WIDTH-1:0]      ent_master_id,
    output logic [cache_geom_pkg::TAG_WIDTH-1:0]            ent_tag,
    output logic [cache_geom_pkg::INDEX_WIDTH-1:0]          ent_index,
    output logic [cache_geom_pkg::OFFSET_WIDTH-1:0]         ent_offset,
    output logic [cache_geom_pkg::WAY_WIDTH-1:0]            ent_way,
    output logic [cache_geom_pkg::ROB_ID_WIDTH-1:0]         ent_rob_id,
    output logic [cache_geom_pkg::DB_ID_WIDTH-1:0]          ent_db_id
);

    // classify the incoming payload for the upd_en cycle
    assign new_is_read  = (upd_opcode == cache_cmd_pkg::CMD_READ);
    assign new_is_write = (upd_opcode == cache_cmd_pkg::CMD_WRITE);
    assign new_miss     = ~upd_hit;

    // ==================================================================
    // entry register
    // ==================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_opcode    <= cache_cmd_pkg::CMD_READ;
            ent_direction <= cache_cmd_pkg::DIR_WEST;
            ent_master_id <= '0;
            ent_tag       <= '0;
            ent_index     <= '0;
            ent_offset    <= '0;
            ent_way       <= '0;
            ent_rob_id    <= '0;
        end else if (upd_en) begin
            ent_opcode    <= upd_opcode;
            ent_direction <= upd_direction;
            ent_master_id <= upd_master_id;
            ent_tag       <= upd_tag;
            ent_index     <= upd_index;
            ent_offset    <= upd_offset;
            ent_way       <= upd_way;
            ent_rob_id    <= upd_rob_id;
        end
    end

    // db id comes back with the fill and a new request wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ent_db_id <= '0;
        end else if (upd_en) begin
            ent_db_id <= '0;
        end else if (ds_done) begin
            ent_db_id <= ds_done_db_id;
        end
    end

endmodule

// File: verilog/cache_cmd_pkg.sv
package cache_cmd_pkg;

    // ==================================================================
    // transaction opcode
    // ==================================================================
    typedef enum logic [1:0] {
        CMD_READ,
        CMD_WRITE
    } cmd_opcode_t;

    // ==================================================================
    // data ram channel, bit i of a per-direction vector is direction i
    // ==================================================================
    typedef enum logic [1:0] {
        DIR_WEST  = 2'd0,
        DIR_EAST  = 2'd1,
        DIR_SOUTH = 2'd2,
        DIR_NORTH = 2'd3
    } direction_t;

    parameter int NUM_DIRS = 4;

endpackage

// File: verilog/cache_geom_pkg.sv
package cache_geom_pkg;

    // ==================================================================
    // address fields
    // ==================================================================
    parameter int TAG_WIDTH       = 20;
    parameter int INDEX_WIDTH     = 8;
    parameter int OFFSET_WIDTH    = 6;
    parameter int WAY_WIDTH       = 3;

    // ==================================================================
    // ids
    // ==================================================================
    parameter int ROB_ID_WIDTH    = 5;
    parameter int DB_ID_WIDTH     = 4;   // linefill data buffer entry
    parameter int MASTER_ID_WIDTH = 4;

    // dest ram id is tag top bits then index top bits
    parameter int HASH_WIDTH      = 2;
    parameter int DEST_RAM_WIDTH  = 5;

endpackage
